/* rtl/dp_imm_cfg.svh */
`ifndef DP_IMM_CFG_SVH
`define DP_IMM_CFG_SVH

// Data and address width
`define DP_XLEN 64

// Physical register count
`define DP_NUM_PRN 32

// Instruction id width, ids wrap at 2**DP_ID_W
`define DP_ID_W 6

`endif

/* rtl/dp_imm_pkg.sv */
`include "dp_imm_cfg.svh"

package dp_imm_pkg;

  // Register value or PC
  typedef logic [`DP_XLEN-1:0] word_t;

  // Raw A64 encoding
  typedef logic [31:0] inst_t;

  typedef logic [$clog2(`DP_NUM_PRN)-1:0] prn_t;  // Physical register number

  typedef logic [`DP_ID_W-1:0] inst_id_t;  // Instruction tag

  // One instruction in flight at a time
  typedef enum logic [1:0] {
    IDLE,
    READ,
    EXEC,
    WRITE
  } issue_state_e;

endpackage

/* rtl/issue_fsm.sv */
`timescale 1ns/1ps

module issue_fsm (
  input  logic                  fu,
  input  logic                  rst,
  input  logic                  issue,
  input  dp_imm_pkg::inst_t     inst,
  input  dp_imm_pkg::word_t     pc,
  input  dp_imm_pkg::prn_t      src_prn,
  input  dp_imm_pkg::prn_t      dst_prn,
  output logic                  ready,
  output logic                  accept,
  output logic                  rf_rd_en,
  output dp_imm_pkg::prn_t      rf_rd_prn,
  output logic                  fu_start,
  output logic                  wr_en,
  output dp_imm_pkg::inst_t     held_inst,
  output dp_imm_pkg::word_t     held_pc,
  output dp_imm_pkg::prn_t      held_dst
);
  import dp_imm_pkg::*;

  issue_state_e state;

  always_ff @(posedge fu) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (accept) state <= READ;
        READ:    state <= EXEC;  // Operand lands in rd_data here
        EXEC:    state <= WRITE;
        WRITE:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Issue buffer, loaded only when an instruction is taken
  always_ff @(posedge fu) begin
    if (accept) begin
      held_inst <= inst;
      held_pc   <= pc;
      held_dst  <= dst_prn;
      rf_rd_prn <= src_prn;
    end
  end

  assign ready    = (state == IDLE);
  assign accept   = issue && ready;
  assign rf_rd_en = (state == READ);
  assign fu_start = (state == EXEC);
  assign wr_en    = (state == WRITE);  // FU result is registered by now

  // Issue port has no queue behind it
  a_no_issue_when_busy : assert property (
    @(posedge fu) disable iff (rst) !(issue && !ready)
  );

  // Register file read takes exactly one cycle
  a_read_one_cycle : assert property (
    @(posedge fu) disable iff (rst) (state == READ) |=> (state != READ)
  );

endmodule

/* rtl/inst_id_counter.sv */
`timescale 1ns/1ps

module inst_id_counter (
  input  logic                  fu,
  input  logic                  rst,
  input  logic                  accept,
  input  logic                  done,
  output dp_imm_pkg::inst_id_t  next_id,
  output logic [15:0]           retired
);
  import dp_imm_pkg::*;

  // next_id tags the instruction in flight and moves on when it completes,
  // so the FU still sees it at its start edge
  always_ff @(posedge fu) begin
    if (rst) begin
      next_id <= '0;
      retired <= '0;
    end else if (done) begin
      next_id <= next_id + 1'b1;  // Wraps at 2**DP_ID_W
      if (retired != '1)
        retired <= retired + 1'b1;  // Saturates
    end
  end

  // A new issue is only taken once the previous one has completed
  a_accept_done_apart : assert property (
    @(posedge fu) disable iff (rst) !(accept && done)
  );

endmodule

/* rtl/phys_reg_file.sv */
`timescale 1ns/1ps
`include "dp_imm_cfg.svh"

module phys_reg_file (
  input  logic                  fu,
  input  logic                  rst,
  input  logic                  rd_en,
  input  dp_imm_pkg::prn_t      rd_prn,
  output dp_imm_pkg::word_t     rd_data,
  input  logic                  wr_en,
  input  dp_imm_pkg::prn_t      wr_prn,
  input  dp_imm_pkg::word_t     wr_data
);
  import dp_imm_pkg::*;

  word_t regs [`DP_NUM_PRN];

  // Write port
  always_ff @(posedge fu) begin
    if (rst) begin
      for (int i = 0; i < `DP_NUM_PRN; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_prn] <= wr_data;
    end
  end

  // Registered read port, holds its value between reads
  always_ff @(posedge fu) begin
    if (rst) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= regs[rd_prn];
    end
  end

endmodule

/* rtl/dp_imm_fu.sv */
`timescale 1ns/1ps
`include "dp_imm_cfg.svh"

module dp_imm_fu (
  input  logic                  fu,
  input  logic                  rst,
  input  logic                  start,
  input  dp_imm_pkg::inst_t     inst,
  input  dp_imm_pkg::word_t     pc,
  input  dp_imm_pkg::inst_id_t  id,
  input  dp_imm_pkg::prn_t      dst,
  input  dp_imm_pkg::word_t     src_data,
  output logic                  done,
  output dp_imm_pkg::inst_id_t  done_id,
  output dp_imm_pkg::prn_t      done_prn,
  output logic                  done_we,
  output dp_imm_pkg::word_t     done_data
);
  import dp_imm_pkg::*;

  // Opcode patterns, 64-bit forms only
  localparam logic [8:0] MOVK_OP = 9'b111100101;  // inst[31:23]
  localparam logic [8:0] MOVZ_OP = 9'b110100101;
  localparam logic [4:0] ADR_OP  = 5'b10000;      // inst[28:24], bit 31 picks ADRP

  logic [1:0]  hw;
  logic [15:0] imm16;
  logic [20:0] imm21;
  word_t       adr_off;
  word_t       result;
  logic        valid_op;

  assign hw    = inst[22:21];
  assign imm16 = inst[20:5];
  assign imm21 = {inst[23:5], inst[30:29]};  // immhi:immlo

  // Sign-extended ADR/ADRP offset
  assign adr_off = {{(`DP_XLEN-21){imm21[20]}}, imm21};

  always_comb begin
    result   = '0;
    valid_op = 1'b0;
    if (inst[31:23] == MOVK_OP) begin
      result = src_data;  // Keep the other three halfwords
      result[{hw, 4'b0000} +: 16] = imm16;
      valid_op = 1'b1;
    end else if (inst[31:23] == MOVZ_OP) begin
      result[{hw, 4'b0000} +: 16] = imm16;
      valid_op = 1'b1;
    end else if (inst[28:24] == ADR_OP) begin
      if (inst[31]) begin
        // ADRP works on 4 KiB pages
        result = {pc[`DP_XLEN-1:12], 12'b0} + (adr_off << 12);
      end else begin
        result = pc + adr_off;
      end
      valid_op = 1'b1;
    end
  end

  always_ff @(posedge fu) begin
    if (rst) begin
      done    <= 1'b0;
      done_we <= 1'b0;
    end else begin
      done <= start;  // One cycle per start
      if (start)
        done_we <= valid_op;  // Unknown encodings complete without a write
    end
  end

  always_ff @(posedge fu) begin
    if (start) begin
      done_id   <= id;
      done_prn  <= dst;
      done_data <= result;
    end
  end

  // Back-to-back starts would mean a second instruction in flight
  a_done_pulse : assert property (
    @(posedge fu) disable iff (rst) done |=> !done
  );

endmodule

/* rtl/dp_imm_slice.sv */
`timescale 1ns/1ps

module dp_imm_slice (
  input  logic                  fu,
  input  logic                  rst,
  input  logic                  issue,
  input  dp_imm_pkg::inst_t     inst,
  input  dp_imm_pkg::word_t     pc,
  input  dp_imm_pkg::prn_t      src_prn,
  input  dp_imm_pkg::prn_t      dst_prn,
  output logic                  ready,
  output logic                  done,
  output dp_imm_pkg::inst_id_t  done_id,
  output dp_imm_pkg::prn_t      done_prn,
  output logic                  done_we,
  output dp_imm_pkg::word_t     done_data,
  output logic [15:0]           retired
);
  import dp_imm_pkg::*;

  logic     accept;
  logic     rf_rd_en;
  prn_t     rf_rd_prn;
  logic     fu_start;
  logic     wr_en;
  inst_t    held_inst;
  word_t    held_pc;
  prn_t     held_dst;
  word_t    rd_data;
  inst_id_t next_id;

  issue_fsm issue_fsm_inst (
    .fu(fu), .rst(rst), .issue(issue), .inst(inst), .pc(pc),
    .src_prn(src_prn), .dst_prn(dst_prn), .ready(ready), .accept(accept),
    .rf_rd_en(rf_rd_en), .rf_rd_prn(rf_rd_prn), .fu_start(fu_start),
    .wr_en(wr_en), .held_inst(held_inst), .held_pc(held_pc),
    .held_dst(held_dst)
  );

  inst_id_counter inst_id_counter_inst (
    .fu(fu), .rst(rst), .accept(accept), .done(done),
    .next_id(next_id), .retired(retired)
  );

  // Write-back from the registered FU outputs during WRITE
  phys_reg_file phys_reg_file_inst (
    .fu(fu), .rst(rst), .rd_en(rf_rd_en), .rd_prn(rf_rd_prn),
    .rd_data(rd_data), .wr_en(wr_en && done_we), .wr_prn(done_prn),
    .wr_data(done_data)
  );

  dp_imm_fu dp_imm_fu_inst (
    .fu(fu), .rst(rst), .start(fu_start), .inst(held_inst), .pc(held_pc),
    .id(next_id), .dst(held_dst), .src_data(rd_data), .done(done),
    .done_id(done_id), .done_prn(done_prn), .done_we(done_we),
    .done_data(done_data)
  );

endmodule

/* bench/dp_imm_tb.sv */
`timescale 1ns/1ps
`include "dp_imm_cfg.svh"

module dp_imm_tb;
  import dp_imm_pkg::*;

  localparam int CYCLE_NS     = 4;
  localparam int RESET_CYCLES = 5;
  localparam int TABLE_LEN    = 72;  // Long enough to wrap the id
  localparam int DONE_LIMIT   = 8;

  // Instruction kinds in the table
  localparam logic [2:0] K_MOVZ   = 3'd0;
  localparam logic [2:0] K_MOVK   = 3'd1;
  localparam logic [2:0] K_ADR    = 3'd2;
  localparam logic [2:0] K_ADRP   = 3'd3;
  localparam logic [2:0] K_NOP    = 3'd4;
  localparam logic [2:0] K_MOVZ32 = 3'd5;  // 32-bit form that the slice does not execute

  typedef struct packed {
    logic [2:0]  kind;
    logic [1:0]  hw;
    logic [15:0] imm16;
    logic [20:0] imm21;
    word_t       pc;
    prn_t        src;
    prn_t        dst;
    inst_t       inst;
    logic        exp_we;
    word_t       exp_data;
  } entry_t;

  logic       fu = 1'b0;
  logic       rst;
  logic       issue;
  inst_t      inst;
  word_t      pc;
  prn_t       src_prn;
  prn_t       dst_prn;
  logic       ready;
  logic       done;
  inst_id_t   done_id;
  prn_t       done_prn;
  logic       done_we;
  word_t      done_data;
  logic [15:0] retired;

  entry_t      tab [TABLE_LEN];
  int          n_entries = 0;
  int          errors = 0;
  logic [31:0] lfsr = 32'ha7de9adb;

  always #(CYCLE_NS / 2) fu = ~fu;

  dp_imm_slice dp_imm_slice_inst (
    .fu(fu), .rst(rst), .issue(issue), .inst(inst), .pc(pc),
    .src_prn(src_prn), .dst_prn(dst_prn), .ready(ready), .done(done),
    .done_id(done_id), .done_prn(done_prn), .done_we(done_we),
    .done_data(done_data), .retired(retired)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // A64 encodings built field by field
  function automatic inst_t encode(input logic [2:0] kind, input logic [1:0] hw,
                                   input logic [15:0] imm16, input logic [20:0] imm21,
                                   input prn_t rd);
    case (kind)
      K_MOVZ:  return {1'b1, 2'b10, 6'b100101, hw, imm16, rd};
      K_MOVK:  return {1'b1, 2'b11, 6'b100101, hw, imm16, rd};
      K_ADR:   return {1'b0, imm21[1:0], 5'b10000, imm21[20:2], rd};
      K_ADRP:  return {1'b1, imm21[1:0], 5'b10000, imm21[20:2], rd};
      K_NOP:   return 32'hd503201f;
      default: return {1'b0, 2'b10, 6'b100101, hw, imm16, rd};
    endcase
  endfunction

  function automatic word_t model_result(input logic [2:0] kind, input logic [1:0] hw,
                                         input logic [15:0] imm16, input logic [20:0] imm21,
                                         input word_t pc_v, input word_t src_val);
    word_t lane_mask;
    word_t imm_lane;
    word_t offset;
    lane_mask = 64'hffff << (16 * hw);
    imm_lane  = word_t'(imm16) << (16 * hw);
    offset    = $signed(imm21);
    case (kind)
      K_MOVZ:  return imm_lane;
      K_MOVK:  return (src_val & ~lane_mask) | imm_lane;
      K_ADR:   return pc_v + offset;
      K_ADRP:  return (pc_v & ~word_t'(12'hfff)) + (offset << 12);  // Page base plus offset
      default: return '0;
    endcase
  endfunction

  task automatic add_entry(input logic [2:0] kind, input logic [1:0] hw,
                           input logic [15:0] imm16, input logic [20:0] imm21,
                           input word_t pc_v, input prn_t src, input prn_t dst);
    tab[n_entries] = '{kind, hw, imm16, imm21, pc_v, src, dst,
                       encode(kind, hw, imm16, imm21, dst), 1'b0, 64'd0};
    n_entries++;
  endtask

  task automatic build_table();
    logic [63:0] r_kind;
    logic [63:0] r_hw;
    logic [63:0] r_imm16;
    logic [63:0] r_imm21;
    logic [63:0] r_pc;
    logic [63:0] r_src;
    logic [63:0] r_dst;
    add_entry(K_MOVK, 2'd2, 16'hbeef, 21'd0, 64'd0, 5'd7, 5'd7);  // Never written
    add_entry(K_MOVZ, 2'd0, 16'h1111, 21'd0, 64'd0, 5'd0, 5'd1);
    add_entry(K_MOVZ, 2'd1, 16'h2222, 21'd0, 64'd0, 5'd0, 5'd2);
    add_entry(K_MOVZ, 2'd2, 16'h3333, 21'd0, 64'd0, 5'd0, 5'd3);
    add_entry(K_MOVZ, 2'd3, 16'h4444, 21'd0, 64'd0, 5'd0, 5'd4);
    add_entry(K_MOVZ, 2'd0, 16'h1234, 21'd0, 64'd0, 5'd0, 5'd5);
    add_entry(K_MOVK, 2'd3, 16'habcd, 21'd0, 64'd0, 5'd5, 5'd5);  // Merge into r5
    add_entry(K_MOVK, 2'd1, 16'h5678, 21'd0, 64'd0, 5'd1, 5'd6);
    add_entry(K_ADR, 2'd0, 16'd0, 21'h0abcd, 64'h0000_0040_0000_1234, 5'd0, 5'd9);
    add_entry(K_ADR, 2'd0, 16'd0, 21'h1fff00, 64'h0000_0040_0000_1234, 5'd0, 5'd10);
    add_entry(K_ADR, 2'd0, 16'd0, 21'h0fffff, 64'h0000_0000_0000_0010, 5'd0, 5'd13);
    add_entry(K_ADRP, 2'd0, 16'd0, 21'h00123, 64'h0000_0000_1234_5678, 5'd0, 5'd11);
    add_entry(K_ADRP, 2'd0, 16'd0, 21'h1ffffe, 64'h0000_7fff_0000_0abc, 5'd0, 5'd12);
    add_entry(K_NOP, 2'd0, 16'd0, 21'd0, 64'd0, 5'd0, 5'd5);      // Must not touch r5
    add_entry(K_MOVZ32, 2'd1, 16'hdead, 21'd0, 64'd0, 5'd0, 5'd5);
    add_entry(K_MOVK, 2'd1, 16'h0f0f, 21'd0, 64'd0, 5'd5, 5'd8);  // Reads r5 back
    // Random rest uses a small register range so MOVK finds earlier results
    while (n_entries < TABLE_LEN) begin
      take_bits(3, r_kind);
      take_bits(2, r_hw);
      take_bits(16, r_imm16);
      take_bits(21, r_imm21);
      take_bits(64, r_pc);
      take_bits(3, r_src);
      take_bits(3, r_dst);
      add_entry(3'(int'(r_kind[2:0]) % 6), r_hw[1:0], r_imm16[15:0], r_imm21[20:0],
                r_pc, 5'(r_src[2:0]), 5'(r_dst[2:0]));
    end
  endtask

  task automatic compute_expected();
    word_t model_regs [`DP_NUM_PRN];
    for (int r = 0; r < `DP_NUM_PRN; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < TABLE_LEN; i++) begin
      tab[i].exp_we   = (tab[i].kind <= K_ADRP);
      tab[i].exp_data = model_result(tab[i].kind, tab[i].hw, tab[i].imm16, tab[i].imm21,
                                     tab[i].pc, model_regs[tab[i].src]);
      if (tab[i].exp_we)
        model_regs[tab[i].dst] = tab[i].exp_data;
    end
  endtask

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  initial begin : main
    int cycles;
    rst     = 1'b1;
    issue   = 1'b0;
    inst    = '0;
    pc      = '0;
    src_prn = '0;
    dst_prn = '0;
    build_table();
    compute_expected();
    repeat (RESET_CYCLES) @(posedge fu);
    #0.5;
    rst = 1'b0;
    check("ready", 64'(ready), 64'd1);
    check("done", 64'(done), 64'd0);
    check("retired", 64'(retired), 64'd0);
    for (int i = 0; i < TABLE_LEN; i++) begin
      cycles = 0;
      while (!ready && cycles < DONE_LIMIT) begin
        @(posedge fu);
        #0.5;
        cycles++;
      end
      if (!ready) begin
        $display("ready stayed low before entry %0d could be issued", i);
        errors++;
      end
      issue   = 1'b1;
      inst    = tab[i].inst;
      pc      = tab[i].pc;
      src_prn = tab[i].src;
      dst_prn = tab[i].dst;
      @(posedge fu);  // Edge k
      #0.5;
      issue = 1'b0;
      cycles = 0;
      while (!done && cycles < DONE_LIMIT) begin
        check("ready", 64'(ready), 64'd0);  // Busy in READ and EXEC
        @(posedge fu);
        #0.5;
        cycles++;
      end
      if (!done) begin
        $display("Entry %0d got no done within %0d cycles", i, DONE_LIMIT);
        errors++;
      end else begin
        check("done latency", 64'(cycles), 64'd2);
        check("done_id", 64'(done_id), 64'(inst_id_t'(i)));
        check("done_prn", 64'(done_prn), 64'(tab[i].dst));
        check("done_we", 64'(done_we), 64'(tab[i].exp_we));
        if (tab[i].exp_we)
          check("done_data", done_data, tab[i].exp_data);
        check("ready", 64'(ready), 64'd0);  // Still in WRITE
        @(posedge fu);  // Edge k+3
        #0.5;
        check("ready", 64'(ready), 64'd1);
        check("done", 64'(done), 64'd0);
        check("retired", 64'(retired), 64'(i + 1));
      end
    end
    $display("Run finished: %0d entries, %0d errors", TABLE_LEN, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Generous bound on the whole table
  initial begin : watchdog
    #((RESET_CYCLES + 20 * TABLE_LEN) * CYCLE_NS);
    $display("Watchdog expired before the table was fully applied");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/dp_imm_pkg.sv
rtl/issue_fsm.sv
rtl/inst_id_counter.sv
rtl/phys_reg_file.sv
rtl/dp_imm_fu.sv
rtl/dp_imm_slice.sv
bench/dp_imm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -f flist.f --top-module dp_imm_tb \
  -o dp_imm_sim && ./obj_dir/dp_imm_sim 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Simulation completed successfully' && exit 0 || exit 1
